//--- all.f
common/z80_int_pkg.sv
verilog/ir_registers.sv
int_control/int_controller.sv
verilog/z80_int_unit.sv
verification/z80_int_checks.sv
verification/tb_z80_int_unit.sv

//--- common/z80_int_pkg.sv
`default_nettype none

// Shared types and constants of the Z80 interrupt unit.
package z80_int_pkg;

  // Interrupt mode as set by IM 0, IM 1 and IM 2.
  typedef enum logic [1:0] {
    IM0 = 2'd0,
    IM1 = 2'd1,
    IM2 = 2'd2
  } int_mode_t;

  // Interrupt related strobes of one instruction.
  // At most one strobe is high in a cycle.
  typedef struct packed {
    logic      ei;
    logic      di;
    logic      retn;
    logic      set_im;
    logic      ld_i;
    logic      ld_r;
    // Mode operand of IM n.
    int_mode_t im;
    // Accumulator value for LD I,A and LD R,A.
    logic [7:0] data;
  } int_op_t;

  // Source of an accepted interrupt.
  typedef enum logic [1:0] {
    KIND_NONE = 2'd0,
    KIND_NMI  = 2'd1,
    KIND_IRQ  = 2'd2
  } int_kind_t;

  // Acknowledge pulse towards the sequencer.
  typedef struct packed {
    logic        valid;
    int_kind_t   kind;
    logic [15:0] vector;
  } int_ack_t;

  // Fixed restart addresses.
  localparam logic [15:0] NMI_VECTOR = 16'h0066;
  localparam logic [15:0] IM1_VECTOR = 16'h0038;

endpackage

`default_nettype wire

//--- int_control/int_controller.sv
`timescale 1ns/1ps
`default_nettype none

// Interrupt controller.
// Decodes operation strobes, captures NMI, keeps the interrupt mode
// and arbitrates requests at instruction boundaries.
module int_controller
  import z80_int_pkg::*;
(
  input  logic       clk,
  input  logic       reset,

  // From the instruction sequencer.
  input  int_op_t    op,
  input  logic       insn_done,

  // Interrupt pins and the device byte.
  input  logic       nmi_n,
  input  logic       int_n,
  input  logic [7:0] bus_vector,

  // Feedback from the register block.
  input  logic [7:0] reg_i,
  input  logic       iff1,

  output int_mode_t  int_mode,
  output int_ack_t   ack,

  // Control of the register block.
  output logic       i_wr,
  output logic [7:0] i_in,
  output logic       r_wr,
  output logic [7:0] r_in,
  output logic       enable_interrupts,
  output logic       disable_interrupts,
  output logic       accept_nmi,
  output logic       ret_from_nmi,
  output logic       next_insn_done
);

  // NMI synchronizer and edge detect.
  logic [1:0] nmi_sync;
  logic       nmi_prev;
  logic       nmi_fall;
  logic       nmi_pending;

  // Boundary arbitration.
  logic       boundary;
  logic       accept_irq;

  // Registered acknowledge.
  logic        ack_valid;
  int_kind_t   ack_kind;
  logic [15:0] ack_vector;
  logic [15:0] irq_vector;

  // Plain decode of the operation strobes.
  assign i_wr              = op.ld_i;
  assign i_in              = op.data;
  assign r_wr              = op.ld_r;
  assign r_in              = op.data;
  assign enable_interrupts = op.ei;
  assign ret_from_nmi      = op.retn;
  assign next_insn_done    = insn_done;

  // DI clears the flags.
  // So does a maskable acceptance, during the ack cycle.
  // Using the registered ack keeps iff1 out of a combinational loop.
  assign disable_interrupts = op.di | (ack_valid & (ack_kind == KIND_IRQ));

  // nmi_n idles high, so the sync chain resets to ones.
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      nmi_sync <= 2'b11;
      nmi_prev <= 1'b1;
    end else begin
      nmi_sync <= {nmi_sync[0], nmi_n};
      nmi_prev <= nmi_sync[1];
    end
  end

  assign nmi_fall = nmi_prev & ~nmi_sync[1];

  // A new edge wins over the clear.
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      nmi_pending <= 1'b0;
    end else if (nmi_fall) begin
      nmi_pending <= 1'b1;
    end else if (accept_nmi) begin
      nmi_pending <= 1'b0;
    end
  end

  // Mode register.
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      int_mode <= IM0;
    end else if (op.set_im) begin
      int_mode <= op.im;
    end
  end

  // No acceptance on EI or DI, nor in the ack cycle itself.
  assign boundary   = insn_done & ~op.ei & ~op.di & ~ack_valid;
  // NMI first.
  assign accept_nmi = boundary & nmi_pending;
  // iff1 already reads low in the EI shadow.
  assign accept_irq = boundary & ~nmi_pending & ~int_n & iff1;

  // Restart address for a maskable interrupt.
  always_comb begin
    case (int_mode)
      IM1:     irq_vector = IM1_VECTOR;
      // Table entry, bit 0 forced low.
      IM2:     irq_vector = {reg_i, bus_vector[7:1], 1'b0};
      // IM0 treats the byte as an RST opcode.
      default: irq_vector = {8'h00, 2'b00, bus_vector[5:3], 3'b000};
    endcase
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      ack_valid <= 1'b0;
    end else begin
      ack_valid <= accept_nmi | accept_irq;
    end
  end

  always_ff @(posedge clk) begin
    if (accept_nmi) begin
      ack_kind   <= KIND_NMI;
      ack_vector <= NMI_VECTOR;
    end else if (accept_irq) begin
      ack_kind   <= KIND_IRQ;
      ack_vector <= irq_vector;
    end
  end

  assign ack.valid  = ack_valid;
  assign ack.kind   = ack_kind;
  assign ack.vector = ack_vector;

  // At most one strobe per cycle.
  a_one_strobe: assert property (
    @(posedge clk) disable iff (reset)
    $onehot0({op.ei, op.di, op.retn, op.set_im, op.ld_i, op.ld_r})
  );

  // Strobes arrive in the last cycle of their instruction.
  a_strobe_at_boundary: assert property (
    @(posedge clk) disable iff (reset)
    (op.ei || op.di || op.retn || op.set_im || op.ld_i || op.ld_r) |-> insn_done
  );

endmodule

`default_nettype wire

//--- verification/tb_z80_int_unit.sv
`timescale 1ns/1ps
`default_nettype none

// Testbench of the interrupt unit.
// Stands in for the instruction sequencer. Checking lives in z80_int_checks.
module tb_z80_int_unit;
  import z80_int_pkg::*;

  logic       clk = 1'b0;
  logic       reset;
  int_op_t    op;
  logic       insn_done;
  logic       nmi_n;
  logic       int_n;
  logic [7:0] bus_vector;
  logic [7:0] reg_i;
  logic [7:0] reg_r;
  logic       iff1;
  logic       iff2;
  int_mode_t  int_mode;
  int_ack_t   ack;

  integer seed = 32'he9a9_d2fe;
  int     timeouts = 0;
  int     pass_count = 0;
  int     fail_count = 0;

  // 8 ns clock.
  always #4 clk = ~clk;

  z80_int_unit i_dut (.*);

  z80_int_checks i_checks (.*);

  function automatic int error_total();
    return i_checks.errors + timeouts;
  endfunction

  // One single cycle instruction, preceded by an idle cycle.
  task automatic run_insn(input string name, input logic [7:0] arg);
    int_op_t o;
    o = '0;
    if (name == "ei") o.ei = 1'b1;
    else if (name == "di") o.di = 1'b1;
    else if (name == "retn") o.retn = 1'b1;
    else if (name == "im") begin
      o.set_im = 1'b1;
      o.im     = int_mode_t'(arg[1:0]);
    end else if (name == "ld_i") begin
      o.ld_i = 1'b1;
      o.data = arg;
    end else if (name == "ld_r") begin
      o.ld_r = 1'b1;
      o.data = arg;
    end
    @(negedge clk);
    op        = o;
    insn_done = 1'b1;
    @(negedge clk);
    op        = '0;
    insn_done = 1'b0;
  endtask

  // Waits for the ack pulse and steps past it.
  task automatic wait_ack(input string what);
    int cycles;
    cycles = 0;
    while (!ack.valid && cycles < 16) begin
      @(negedge clk);
      cycles++;
    end
    if (ack.valid) begin
      @(negedge clk);
    end else begin
      timeouts++;
      $display("Timeout: no acknowledge for %s within 16 cycles", what);
    end
  endtask

  task automatic end_test(input string name, input int mark);
    if (error_total() == mark) begin
      pass_count++;
      $display("%0t ns: %s ok", $time, name);
    end else begin
      fail_count++;
      $display("%0t ns: %s failed, %0d errors", $time, name, error_total() - mark);
    end
  endtask

  initial begin
    int mark;
    reset      = 1'b1;
    op         = '0;
    insn_done  = 1'b0;
    nmi_n      = 1'b1;
    int_n      = 1'b1;
    bus_vector = 8'h00;
    repeat (4) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    // LD I,A and LD R,A.
    mark = error_total();
    run_insn("ld_i", 8'($random(seed)));
    run_insn("ld_r", 8'($random(seed)));
    end_test("ld_i_ld_r", mark);

    // DI, then EI with a masked request in the shadow.
    mark = error_total();
    run_insn("im", 8'd1);
    // Flags are raised first, so DI has something to clear.
    run_insn("ei", 8'd0);
    run_insn("nop", 8'd0);
    run_insn("di", 8'd0);
    int_n = 1'b0;
    run_insn("ei", 8'd0);
    run_insn("nop", 8'd0);
    int_n = 1'b1;
    run_insn("nop", 8'd0);
    end_test("ei_shadow", mark);

    // IM1 maskable interrupt, then a request while masked.
    mark = error_total();
    int_n = 1'b0;
    run_insn("nop", 8'd0);
    wait_ack("im1 interrupt");
    run_insn("nop", 8'd0);
    run_insn("nop", 8'd0);
    int_n = 1'b1;
    end_test("im1_irq", mark);

    // IM2 and IM0 vectors from a random device byte.
    mark = error_total();
    run_insn("ld_i", 8'($random(seed)));
    run_insn("im", 8'd2);
    run_insn("ei", 8'd0);
    run_insn("nop", 8'd0);
    bus_vector = 8'($random(seed));
    int_n      = 1'b0;
    run_insn("nop", 8'd0);
    wait_ack("im2 interrupt");
    int_n = 1'b1;
    run_insn("im", 8'd0);
    run_insn("ei", 8'd0);
    run_insn("nop", 8'd0);
    bus_vector = 8'($random(seed));
    int_n      = 1'b0;
    run_insn("nop", 8'd0);
    wait_ack("im0 interrupt");
    int_n = 1'b1;
    end_test("im2_im0_vectors", mark);

    // NMI beats a low int_n, then RETN restores iff1.
    mark = error_total();
    run_insn("ei", 8'd0);
    run_insn("nop", 8'd0);
    nmi_n = 1'b0;
    int_n = 1'b0;
    // Sync chain and edge detect need three clocks.
    repeat (5) @(negedge clk);
    run_insn("nop", 8'd0);
    wait_ack("nmi");
    nmi_n = 1'b1;
    int_n = 1'b1;
    run_insn("nop", 8'd0);
    run_insn("retn", 8'd0);
    run_insn("nop", 8'd0);
    end_test("nmi_retn", mark);

    $display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verification/z80_int_checks.sv
`timescale 1ns/1ps
`default_nettype none

// Reference model of the interrupt unit and the assertions against it.
// It only watches the DUT ports.
module z80_int_checks
  import z80_int_pkg::*;
(
  input logic       clk,
  input logic       reset,
  input int_op_t    op,
  input logic       insn_done,
  input logic       nmi_n,
  input logic       int_n,
  input logic [7:0] bus_vector,
  input logic [7:0] reg_i,
  input logic [7:0] reg_r,
  input logic       iff1,
  input logic       iff2,
  input int_mode_t  int_mode,
  input int_ack_t   ack
);

  int errors = 0;

  // Model state.
  logic [7:0]  m_i;
  logic [7:0]  m_r;
  int_mode_t   m_mode;
  logic        m_iff1;
  logic        m_iff2;
  logic        m_shadow;
  logic [2:0]  nmi_hist;
  logic        nmi_seen;
  logic        m_ack_valid;
  int_kind_t   m_ack_kind;
  logic [15:0] m_ack_vector;

  logic        vis_iff1;
  logic        vis_iff2;
  logic        boundary;
  logic        take_nmi;
  logic        take_irq;
  logic [15:0] irq_vector;

  // Flags read low in the EI and DI cycles and in the EI shadow.
  assign vis_iff1 = m_iff1 & ~m_shadow & ~op.ei & ~op.di;
  assign vis_iff2 = m_iff2 & ~m_shadow & ~op.ei & ~op.di;

  // NMI wins over a maskable request.
  assign boundary = insn_done & ~op.ei & ~op.di;
  assign take_nmi = boundary & nmi_seen;
  assign take_irq = boundary & ~nmi_seen & ~int_n & vis_iff1;

  // Restart address per interrupt mode.
  always_comb begin
    case (m_mode)
      IM1:     irq_vector = IM1_VECTOR;
      IM2:     irq_vector = {m_i, bus_vector & 8'hfe};
      default: irq_vector = {13'd0, bus_vector[5:3]} * 16'd8;
    endcase
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      m_i          <= 8'h00;
      m_r          <= 8'h00;
      m_mode       <= IM0;
      m_iff1       <= 1'b0;
      m_iff2       <= 1'b0;
      m_shadow     <= 1'b0;
      nmi_hist     <= 3'b111;
      nmi_seen     <= 1'b0;
      m_ack_valid  <= 1'b0;
      m_ack_kind   <= KIND_NONE;
      m_ack_vector <= 16'h0000;
    end else begin
      nmi_hist <= {nmi_hist[1:0], nmi_n};
      if (op.ld_i) begin
        m_i <= op.data;
      end
      if (op.ld_r) begin
        m_r <= op.data;
      end
      if (op.set_im) begin
        m_mode <= op.im;
      end
      // A falling nmi_n becomes a request three clocks after the edge.
      // It stays until it is taken.
      if (nmi_hist[2] && !nmi_hist[1]) begin
        nmi_seen <= 1'b1;
      end else if (take_nmi) begin
        nmi_seen <= 1'b0;
      end
      m_ack_valid <= take_nmi | take_irq;
      if (take_nmi) begin
        m_ack_kind   <= KIND_NMI;
        m_ack_vector <= NMI_VECTOR;
      end else if (take_irq) begin
        m_ack_kind   <= KIND_IRQ;
        m_ack_vector <= irq_vector;
      end
      // Any finished instruction ends the shadow. EI below starts a new one.
      if (insn_done) begin
        m_shadow <= 1'b0;
      end
      if (op.di) begin
        m_iff1 <= 1'b0;
        m_iff2 <= 1'b0;
      end else if (op.ei) begin
        m_iff1   <= 1'b1;
        m_iff2   <= 1'b1;
        m_shadow <= 1'b1;
      end else if (take_nmi) begin
        m_iff1 <= 1'b0;
        m_iff2 <= m_iff1;
      end else if (take_irq) begin
        m_iff1 <= 1'b0;
        m_iff2 <= 1'b0;
      end else if (op.retn) begin
        m_iff1 <= m_iff2;
      end
    end
  end

  task automatic note_error(input string msg);
    errors++;
    $display("** Error at %0t ns: %s", $time, msg);
  endtask

  a_reg_i: assert property (@(posedge clk) disable iff (reset) reg_i == m_i)
    else note_error($sformatf("reg_i is %h, expected %h", $sampled(reg_i), $sampled(m_i)));
  a_reg_r: assert property (@(posedge clk) disable iff (reset) reg_r == m_r)
    else note_error($sformatf("reg_r is %h, expected %h", $sampled(reg_r), $sampled(m_r)));
  a_mode: assert property (@(posedge clk) disable iff (reset) int_mode == m_mode)
    else note_error($sformatf("int_mode is %0d, expected %0d", $sampled(int_mode),
                              $sampled(m_mode)));
  a_iff1: assert property (@(posedge clk) disable iff (reset) iff1 == vis_iff1)
    else note_error($sformatf("iff1 is %b, expected %b", $sampled(iff1), $sampled(vis_iff1)));
  a_iff2: assert property (@(posedge clk) disable iff (reset) iff2 == vis_iff2)
    else note_error($sformatf("iff2 is %b, expected %b", $sampled(iff2), $sampled(vis_iff2)));
  // DI masks in its own cycle.
  a_di_low: assert property (@(posedge clk) disable iff (reset) op.di |-> !iff1 && !iff2)
    else note_error("flags not low in the DI cycle");
  a_ack_valid: assert property (@(posedge clk) disable iff (reset) ack.valid == m_ack_valid)
    else note_error($sformatf("ack.valid is %b, expected %b", $sampled(ack.valid),
                              $sampled(m_ack_valid)));
  a_ack_payload: assert property (@(posedge clk) disable iff (reset)
    ack.valid |-> (ack.kind == m_ack_kind) && (ack.vector == m_ack_vector))
    else note_error($sformatf("ack kind %0d vector %h, expected kind %0d vector %h",
                              $sampled(ack.kind), $sampled(ack.vector),
                              $sampled(m_ack_kind), $sampled(m_ack_vector)));

endmodule

`default_nettype wire

//--- verilog/ir_registers.sv
`timescale 1ns/1ps
`default_nettype none

// I and R registers plus the two interrupt enable flip-flops.
// EI takes effect only after the instruction that follows it.
module ir_registers (
  input  logic       clk,
  input  logic       reset,

  // Register writes from LD I,A and LD R,A.
  input  logic       i_wr,
  input  logic [7:0] i_in,
  input  logic       r_wr,
  input  logic [7:0] r_in,

  // Flag control.
  input  logic       enable_interrupts,
  input  logic       disable_interrupts,
  input  logic       accept_nmi,
  input  logic       ret_from_nmi,
  // Current instruction completes at the next rising edge.
  input  logic       next_insn_done,

  output logic [7:0] reg_i,
  output logic [7:0] reg_r,
  output logic       iff1,
  output logic       iff2
);

  // Flags as stored, before gating.
  logic int_iff1;
  logic int_iff2;

  // Set by EI. Cleared when the following instruction ends.
  logic delayed_enable;

  // Visible flags are forced low while interrupts must not be taken.
  // This covers reset, the DI cycle, the EI cycle and the EI shadow.
  logic flag_block;

  assign flag_block = reset | disable_interrupts | enable_interrupts | delayed_enable;

  assign iff1 = int_iff1 & ~flag_block;
  assign iff2 = int_iff2 & ~flag_block;

  // I register.
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      reg_i <= 8'h00;
    end else if (i_wr) begin
      reg_i <= i_in;
    end
  end

  // R register.
  // No refresh count here, only LD R,A changes it.
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      reg_r <= 8'h00;
    end else if (r_wr) begin
      reg_r <= r_in;
    end
  end

  // Interrupt enable flags.
  // Priority is DI, then EI, then NMI accept, then RETN.
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      int_iff1       <= 1'b0;
      int_iff2       <= 1'b0;
      delayed_enable <= 1'b0;
    end else begin
      if (disable_interrupts) begin
        int_iff1       <= 1'b0;
        int_iff2       <= 1'b0;
        delayed_enable <= 1'b0;
      end else if (enable_interrupts) begin
        // Stored now, but held invisible for one more instruction.
        int_iff1       <= 1'b1;
        int_iff2       <= 1'b1;
        delayed_enable <= 1'b1;
      end else if (accept_nmi) begin
        // IFF2 remembers the mask state for RETN.
        int_iff1       <= 1'b0;
        int_iff2       <= int_iff1;
        delayed_enable <= 1'b0;
      end else if (ret_from_nmi) begin
        int_iff1       <= int_iff2;
        delayed_enable <= 1'b0;
      end else if (next_insn_done && delayed_enable) begin
        // Shadow instruction is done.
        delayed_enable <= 1'b0;
      end
    end
  end

  // Flags read low in any cycle with an EI or DI strobe.
  a_flags_low_on_ei_di: assert property (
    @(posedge clk) disable iff (reset)
    (enable_interrupts || disable_interrupts) |-> (!iff1 && !iff2)
  );

  // EI and DI come from different instructions.
  a_ei_di_exclusive: assert property (
    @(posedge clk) disable iff (reset)
    !(enable_interrupts && disable_interrupts)
  );

endmodule

`default_nettype wire

//--- verilog/z80_int_unit.sv
`timescale 1ns/1ps
`default_nettype none

// Interrupt unit top.
// Controller plus I, R and IFF register block.
module z80_int_unit
  import z80_int_pkg::*;
(
  input  logic       clk,
  input  logic       reset,

  input  int_op_t    op,
  input  logic       insn_done,
  input  logic       nmi_n,
  input  logic       int_n,
  input  logic [7:0] bus_vector,

  output logic [7:0] reg_i,
  output logic [7:0] reg_r,
  output logic       iff1,
  output logic       iff2,
  output int_mode_t  int_mode,
  output int_ack_t   ack
);

  // Controller to register block.
  logic       i_wr;
  logic [7:0] i_in;
  logic       r_wr;
  logic [7:0] r_in;
  logic       enable_interrupts;
  logic       disable_interrupts;
  logic       accept_nmi;
  logic       ret_from_nmi;
  logic       next_insn_done;

  int_controller u_int_controller (
    .clk                (clk),
    .reset              (reset),
    .op                 (op),
    .insn_done          (insn_done),
    .nmi_n              (nmi_n),
    .int_n              (int_n),
    .bus_vector         (bus_vector),
    .reg_i              (reg_i),
    .iff1               (iff1),
    .int_mode           (int_mode),
    .ack                (ack),
    .i_wr               (i_wr),
    .i_in               (i_in),
    .r_wr               (r_wr),
    .r_in               (r_in),
    .enable_interrupts  (enable_interrupts),
    .disable_interrupts (disable_interrupts),
    .accept_nmi         (accept_nmi),
    .ret_from_nmi       (ret_from_nmi),
    .next_insn_done     (next_insn_done)
  );

  // Gated iff1 goes back to the controller as its only mask.
  ir_registers u_ir_registers (
    .clk                (clk),
    .reset              (reset),
    .i_wr               (i_wr),
    .i_in               (i_in),
    .r_wr               (r_wr),
    .r_in               (r_in),
    .enable_interrupts  (enable_interrupts),
    .disable_interrupts (disable_interrupts),
    .accept_nmi         (accept_nmi),
    .ret_from_nmi       (ret_from_nmi),
    .next_insn_done     (next_insn_done),
    .reg_i              (reg_i),
    .reg_r              (reg_r),
    .iff1               (iff1),
    .iff2               (iff2)
  );

endmodule

`default_nettype wire
